// ==== hw/aes_settings.svh ====
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// data block and seed widths
`define AES_BLOCK_W 128
`define AES_KEY_W 256

// aes-256 round structure
`define AES_ROUNDS 14
`define AES_NUM_RKEYS 15

// round-key store addressing
`define AES_RKEY_ADDR_W 4

`endif

// ==== hw/aes_pkg.sv ====
`include "aes_settings.svh"

package aes_pkg;

    // command opcodes
    typedef enum logic {
        op_keygen,
        op_encrypt
    } cmd_op_e;

    // payload holds the seed, or the plaintext in its low bits
    typedef struct packed {
        cmd_op_e op;
        logic [`AES_KEY_W-1:0] payload;
    } cmd_t;

    typedef enum logic {
        st_ok,
        st_no_key
    } res_status_e;

    typedef struct packed {
        res_status_e status;
        logic [`AES_BLOCK_W-1:0] block;
    } result_t;

    // device FSM states
    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_keygen,
        ctrl_encrypt,
        ctrl_respond
    } ctrl_state_e;

    // multiply by x modulo the aes polynomial
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add field multiply
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] aa;
        p = 8'h00;
        aa = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ aa;
            aa = xtime(aa);
        end
        return p;
    endfunction

    // forward s-box: inverse as b^254, then the affine map
    function automatic logic [7:0] sbox(input logic [7:0] b);
        logic [7:0] sq;
        logic [7:0] inv;
        sq = b;
        inv = 8'h01;
        // product of b^2 .. b^128
        for (int i = 0; i < 7; i++)
        begin
            sq = gmul(sq, sq);
            inv = gmul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

endpackage

// ==== hw/aes_cmd_port.sv ====
`timescale 1ns/1ps

module aes_cmd_port (
    input  logic           clk,
    input  logic           resetn,
    input  logic           cmd_req,
    input  aes_pkg::cmd_t  cmd,
    input  logic           cmd_take,
    output logic           cmd_ack,
    output logic           cmd_valid,
    output aes_pkg::cmd_t  cmd_data
);

    logic new_req;

    // fresh request only when no command is held and ack is down
    assign new_req = cmd_req && !cmd_ack && !cmd_valid;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            cmd_ack <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            // controller took it, ack goes up next cycle
            if (cmd_take)
            begin
                cmd_valid <= 1'b0;
                cmd_ack <= 1'b1;
            end
            else if (new_req)
                cmd_valid <= 1'b1;
            // requester dropped req, close the handshake
            if (cmd_ack && !cmd_req)
                cmd_ack <= 1'b0;
        end
    end

    // command held stable until the next request
    always_ff @(posedge clk)
    begin
        if (new_req)
            cmd_data <= cmd;
    end

    // ack only answers a live request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        $rose(cmd_ack) |-> cmd_req);

endmodule

// ==== hw/aes_controller.sv ====
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_controller (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   cmd_valid,
    input  aes_pkg::cmd_t          cmd_data,
    input  logic                   kx_done,
    input  logic                   key_loaded,
    input  logic                   enc_done,
    input  logic [`AES_BLOCK_W-1:0] enc_block,
    input  logic                   res_taken,
    output logic                   cmd_take,
    output logic                   kx_start,
    output logic [`AES_KEY_W-1:0]  seed,
    output logic                   enc_start,
    output logic [`AES_BLOCK_W-1:0] plaintext,
    output logic                   res_valid,
    output aes_pkg::result_t       res_data
);

    aes_pkg::ctrl_state_e state;
    logic is_keygen;
    logic no_key;

    // commands only accepted in idle, so respond stalls the channel
    assign cmd_take = (state == aes_pkg::ctrl_idle) && cmd_valid;
    assign is_keygen = (cmd_data.op == aes_pkg::op_keygen);
    assign no_key = cmd_take && !is_keygen && !key_loaded;

    // port holds cmd_data, engines latch it on their start pulse
    assign seed = cmd_data.payload;
    assign plaintext = cmd_data.payload[`AES_BLOCK_W-1:0];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= aes_pkg::ctrl_idle;
            kx_start <= 1'b0;
            enc_start <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            kx_start <= 1'b0;
            enc_start <= 1'b0;
            case (state)
                aes_pkg::ctrl_idle:
                    if (cmd_take)
                    begin
                        if (is_keygen)
                        begin
                            kx_start <= 1'b1;
                            state <= aes_pkg::ctrl_keygen;
                        end
                        else if (key_loaded)
                        begin
                            enc_start <= 1'b1;
                            state <= aes_pkg::ctrl_encrypt;
                        end
                        else
                        begin
                            // no key yet, answer at once
                            res_valid <= 1'b1;
                            state <= aes_pkg::ctrl_respond;
                        end
                    end
                aes_pkg::ctrl_keygen:
                    if (kx_done)
                        state <= aes_pkg::ctrl_idle;
                aes_pkg::ctrl_encrypt:
                    if (enc_done)
                    begin
                        res_valid <= 1'b1;
                        state <= aes_pkg::ctrl_respond;
                    end
                default:
                    if (res_taken)
                    begin
                        res_valid <= 1'b0;
                        state <= aes_pkg::ctrl_idle;
                    end
            endcase
        end
    end

    // result payload
    always_ff @(posedge clk)
    begin
        if (no_key)
        begin
            res_data.status <= aes_pkg::st_no_key;
            res_data.block <= '0;
        end
        else if (state == aes_pkg::ctrl_encrypt && enc_done)
        begin
            res_data.status <= aes_pkg::st_ok;
            res_data.block <= enc_block;
        end
    end

    // only one engine runs at a time
    a_one_engine: assert property (@(posedge clk) disable iff (!resetn)
        !(kx_start && enc_start));

endmodule

// ==== hw/aes_key_expand.sv ====
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_key_expand (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       kx_start,
    input  logic [`AES_KEY_W-1:0]      seed,
    output logic                       kx_done,
    output logic                       rk_we,
    output logic [`AES_RKEY_ADDR_W-1:0] rk_waddr,
    output logic [`AES_BLOCK_W-1:0]    rk_wdata
);

    // last eight schedule words, oldest in the top bits
    logic [`AES_KEY_W-1:0] win;
    logic [`AES_RKEY_ADDR_W-1:0] cnt;
    logic busy;
    logic [31:0] last;
    logic [31:0] temp;
    logic [7:0] rcon;
    logic [31:0] n0, n1, n2, n3;

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {aes_pkg::sbox(w[31:24]), aes_pkg::sbox(w[23:16]),
                aes_pkg::sbox(w[15:8]), aes_pkg::sbox(w[7:0])};
    endfunction

    assign last = win[31:0];
    // rcon doubles every even round key
    assign rcon = 8'h01 << (cnt[3:1] - 3'd1);

    always_comb
    begin
        // even step gets rotword and rcon, odd step subword only
        if (!cnt[0])
            temp = sub_word({last[23:0], last[31:24]}) ^ {rcon, 24'h000000};
        else
            temp = sub_word(last);
    end

    assign n0 = win[255:224] ^ temp;
    assign n1 = win[223:192] ^ n0;
    assign n2 = win[191:160] ^ n1;
    assign n3 = win[159:128] ^ n2;

    // seed halves are round keys 0 and 1
    assign rk_wdata = (cnt == 0) ? win[255:128] :
                      (cnt == 1) ? win[127:0] : {n0, n1, n2, n3};
    assign rk_we = busy;
    assign rk_waddr = cnt;
    assign kx_done = busy && (cnt == `AES_NUM_RKEYS - 1);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            cnt <= '0;
        end
        else if (kx_start)
        begin
            busy <= 1'b1;
            cnt <= '0;
        end
        else if (busy)
        begin
            cnt <= cnt + 1'b1;
            if (kx_done)
                busy <= 1'b0;
        end
    end

    // slide the window by four words per derived key
    always_ff @(posedge clk)
    begin
        if (kx_start)
            win <= seed;
        else if (busy && cnt >= 2)
            win <= {win[127:0], n0, n1, n2, n3};
    end

endmodule

// ==== hw/aes_round_key_store.sv ====
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_round_key_store (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       rk_we,
    input  logic [`AES_RKEY_ADDR_W-1:0] rk_waddr,
    input  logic [`AES_BLOCK_W-1:0]    rk_wdata,
    input  logic [`AES_RKEY_ADDR_W-1:0] rk_raddr,
    output logic [`AES_BLOCK_W-1:0]    rk_rdata,
    output logic                       key_loaded
);

    logic [`AES_BLOCK_W-1:0] mem [`AES_NUM_RKEYS];

    always_ff @(posedge clk)
    begin
        if (rk_we)
            mem[rk_waddr] <= rk_wdata;
    end

    // async read for the cipher core
    assign rk_rdata = mem[rk_raddr];

    // set by the final round key, held until reset
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            key_loaded <= 1'b0;
        else if (rk_we && rk_waddr == `AES_NUM_RKEYS - 1)
            key_loaded <= 1'b1;
    end

    a_waddr_range: assert property (@(posedge clk) disable iff (!resetn)
        rk_we |-> rk_waddr <= `AES_NUM_RKEYS - 1);

endmodule

// ==== hw/aes_cipher_core.sv ====
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_cipher_core (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       enc_start,
    input  logic [`AES_BLOCK_W-1:0]    plaintext,
    input  logic [`AES_BLOCK_W-1:0]    rk_rdata,
    output logic [`AES_RKEY_ADDR_W-1:0] rk_raddr,
    output logic                       enc_done,
    output logic [`AES_BLOCK_W-1:0]    enc_block
);

    logic [`AES_BLOCK_W-1:0] state;
    logic [`AES_BLOCK_W-1:0] round_out;
    logic [`AES_RKEY_ADDR_W-1:0] round;
    logic busy;

    // byte k of the block sits at row k%4, column k/4
    function automatic logic [127:0] sub_shift(input logic [127:0] s);
        logic [127:0] o;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                o[127 - 8 * (r + 4 * c) -: 8] =
                    aes_pkg::sbox(s[127 - 8 * (r + 4 * ((c + r) % 4)) -: 8]);
        return o;
    endfunction

    function automatic logic [127:0] mix_columns(input logic [127:0] s);
        logic [127:0] o;
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++)
        begin
            {a0, a1, a2, a3} = s[127 - 32 * c -: 32];
            // 3a is xtime(a) ^ a
            o[127 - 32 * c -: 32] = {
                aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3,
                aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3)};
        end
        return o;
    endfunction

    assign rk_raddr = round;

    always_comb
    begin
        // round 0 is the bare addroundkey, last round skips mixcolumns
        if (round == 0)
            round_out = state ^ rk_rdata;
        else if (round == `AES_ROUNDS)
            round_out = sub_shift(state) ^ rk_rdata;
        else
            round_out = mix_columns(sub_shift(state)) ^ rk_rdata;
    end

    assign enc_done = busy && (round == `AES_ROUNDS);
    // ciphertext is the final round output, valid with enc_done
    assign enc_block = round_out;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            round <= '0;
        end
        else if (enc_start)
        begin
            busy <= 1'b1;
            round <= '0;
        end
        else if (busy)
        begin
            if (enc_done)
            begin
                busy <= 1'b0;
                round <= '0;
            end
            else
                round <= round + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enc_start)
            state <= plaintext;
        else if (busy)
            state <= round_out;
    end

    a_round_range: assert property (@(posedge clk) disable iff (!resetn)
        round <= `AES_ROUNDS);

endmodule

// ==== hw/aes_result_port.sv ====
`timescale 1ns/1ps

module aes_result_port (
    input  logic              clk,
    input  logic              resetn,
    input  logic              res_valid,
    input  aes_pkg::result_t  res_data,
    input  logic              res_ack,
    output logic              res_req,
    output aes_pkg::result_t  res,
    output logic              res_taken
);

    // ack seen, waiting for it to fall
    logic ack_seen;
    logic load;

    assign load = res_valid && !res_req && !ack_seen;
    // single cycle, ack_seen clears on the same edge
    assign res_taken = ack_seen && !res_ack;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            res_req <= 1'b0;
            ack_seen <= 1'b0;
        end
        else
        begin
            if (load)
                res_req <= 1'b1;
            else if (res_req && res_ack)
            begin
                res_req <= 1'b0;
                ack_seen <= 1'b1;
            end
            else if (res_taken)
                ack_seen <= 1'b0;
        end
    end

    // res only loads while req is low
    always_ff @(posedge clk)
    begin
        if (load)
            res <= res_data;
    end

endmodule

// ==== hw/aes_device.sv ====
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_device (
    input  logic              clk,
    input  logic              resetn,
    input  logic              cmd_req,
    input  aes_pkg::cmd_t     cmd,
    input  logic              res_ack,
    output logic              cmd_ack,
    output logic              res_req,
    output aes_pkg::result_t  res
);

    // command side
    logic cmd_valid;
    logic cmd_take;
    aes_pkg::cmd_t cmd_data;

    // key schedule and store
    logic kx_start;
    logic kx_done;
    logic [`AES_KEY_W-1:0] seed;
    logic rk_we;
    logic [`AES_RKEY_ADDR_W-1:0] rk_waddr;
    logic [`AES_BLOCK_W-1:0] rk_wdata;
    logic key_loaded;

    // cipher
    logic enc_start;
    logic enc_done;
    logic [`AES_BLOCK_W-1:0] plaintext;
    logic [`AES_BLOCK_W-1:0] enc_block;
    logic [`AES_RKEY_ADDR_W-1:0] rk_raddr;
    logic [`AES_BLOCK_W-1:0] rk_rdata;

    // result side
    logic res_valid;
    logic res_taken;
    aes_pkg::result_t res_data;

    aes_cmd_port cmd_port_inst (.clk, .resetn, .cmd_req, .cmd, .cmd_take,
        .cmd_ack, .cmd_valid, .cmd_data);

    aes_controller controller_inst (.clk, .resetn, .cmd_valid, .cmd_data, .kx_done,
        .key_loaded, .enc_done, .enc_block, .res_taken, .cmd_take, .kx_start, .seed,
        .enc_start, .plaintext, .res_valid, .res_data);

    aes_key_expand key_expand_inst (.clk, .resetn, .kx_start, .seed, .kx_done,
        .rk_we, .rk_waddr, .rk_wdata);

    aes_round_key_store key_store_inst (.clk, .resetn, .rk_we, .rk_waddr, .rk_wdata,
        .rk_raddr, .rk_rdata, .key_loaded);

    aes_cipher_core cipher_core_inst (.clk, .resetn, .enc_start, .plaintext, .rk_rdata,
        .rk_raddr, .enc_done, .enc_block);

    aes_result_port result_port_inst (.clk, .resetn, .res_valid, .res_data, .res_ack,
        .res_req, .res, .res_taken);

endmodule

// ==== test/aes_device_tb.sv ====
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_device_tb;

    localparam int wait_limit = 400;
    // fips-197 appendix c.3 vector
    localparam logic [`AES_KEY_W-1:0] kat_key =
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
    localparam logic [`AES_BLOCK_W-1:0] kat_pt = 128'h00112233445566778899aabbccddeeff;
    localparam logic [`AES_BLOCK_W-1:0] kat_ct = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic clk;
    logic resetn;
    logic cmd_req;
    aes_pkg::cmd_t cmd;
    logic res_ack;
    logic cmd_ack;
    logic res_req;
    aes_pkg::result_t res;

    // expected result for the next res_req rise
    aes_pkg::res_status_e exp_status;
    logic [`AES_BLOCK_W-1:0] exp_block;
    logic chk_block;
    logic in_reset_d;
    int check_errors = 0;
    int timeout_errors = 0;

    aes_device aes_device_inst (.clk, .resetn, .cmd_req, .cmd, .res_ack,
        .cmd_ack, .res_req, .res);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // reset seen one edge ago, so flops have had an edge to clear
    always @(posedge clk)
        in_reset_d <= !resetn;

    function automatic void note_failure(input string msg);
        check_errors++;
        $display("Fail %0t: %s", $time, msg);
    endfunction

    function automatic void report_timeout(input string what);
        timeout_errors++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endfunction

    // outputs quiet during reset and just after
    a_reset_quiet: assert property (@(posedge clk) in_reset_d |-> !cmd_ack && !res_req)
        else note_failure("cmd_ack or res_req high around reset");

    // command channel, four phases
    a_cmd_req_rise: assert property (@(posedge clk) disable iff (!resetn)
        $rose(cmd_req) |-> !cmd_ack)
        else note_failure("cmd_req rose while cmd_ack still high");
    a_cmd_ack_rise: assert property (@(posedge clk) disable iff (!resetn)
        $rose(cmd_ack) |-> cmd_req)
        else note_failure("cmd_ack rose without cmd_req");
    // req must already have been low one edge before ack drops
    a_cmd_ack_fall: assert property (@(posedge clk) disable iff (!resetn)
        $fell(cmd_ack) |-> !$past(cmd_req))
        else note_failure("cmd_ack fell before cmd_req fell");
    // a pending result stalls the command channel
    a_cmd_stall: assert property (@(posedge clk) disable iff (!resetn)
        $rose(cmd_ack) |-> !res_req)
        else note_failure("cmd_ack rose while a result was pending");

    // result channel, roles reversed
    a_res_ack_rise: assert property (@(posedge clk) disable iff (!resetn)
        $rose(res_ack) |-> res_req)
        else note_failure("res_ack rose without res_req");
    a_res_ack_fall: assert property (@(posedge clk) disable iff (!resetn)
        $fell(res_ack) |-> !res_req)
        else note_failure("res_ack fell before res_req fell");
    a_res_req_fall: assert property (@(posedge clk) disable iff (!resetn)
        $fell(res_req) |-> res_ack)
        else note_failure("res_req fell without res_ack");
    a_res_stable: assert property (@(posedge clk) disable iff (!resetn)
        res_req && $past(res_req) |-> res == $past(res))
        else note_failure("res changed while res_req high");

    // result value against the expected status and block
    a_result: assert property (@(posedge clk) disable iff (!resetn)
        $rose(res_req) |-> res.status == exp_status && (!chk_block || res.block == exp_block))
        else note_failure($sformatf("result %0d/%h, expected %0d/%h",
            res.status, res.block, exp_status, exp_block));

    task automatic apply_reset();
        @(posedge clk);
        resetn <= 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
    endtask

    task automatic set_expect(input aes_pkg::res_status_e st,
                              input logic [`AES_BLOCK_W-1:0] blk, input logic chk);
        exp_status = st;
        exp_block = blk;
        chk_block = chk;
    endtask

    task automatic send_cmd(input aes_pkg::cmd_op_e op,
                            input logic [`AES_KEY_W-1:0] payload);
        int n;
        @(posedge clk);
        cmd <= '{op: op, payload: payload};
        cmd_req <= 1'b1;
        n = 0;
        while (!cmd_ack && n < wait_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (!cmd_ack)
            report_timeout("cmd_ack to rise");
        cmd_req <= 1'b0;
        n = 0;
        while (cmd_ack && n < wait_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (cmd_ack)
            report_timeout("cmd_ack to fall");
    endtask

    // delay is the back-pressure before res_ack goes up
    task automatic take_result(input int delay, output aes_pkg::result_t r);
        int n;
        n = 0;
        while (!res_req && n < wait_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (!res_req)
            report_timeout("res_req to rise");
        r = res;
        repeat (delay) @(posedge clk);
        res_ack <= 1'b1;
        n = 0;
        while (res_req && n < wait_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (res_req)
            report_timeout("res_req to fall");
        res_ack <= 1'b0;
    endtask

    initial
    begin
        aes_pkg::result_t r;
        logic [`AES_BLOCK_W-1:0] pt;
        void'($urandom(89158));
        resetn = 1'b0;
        cmd_req = 1'b0;
        cmd = '0;
        res_ack = 1'b0;
        set_expect(aes_pkg::st_no_key, '0, 1'b1);
        apply_reset();

        // encrypt with nothing loaded
        send_cmd(aes_pkg::op_encrypt, {128'h0, kat_pt});
        take_result(0, r);

        // known answer
        send_cmd(aes_pkg::op_keygen, kat_key);
        set_expect(aes_pkg::st_ok, kat_ct, 1'b1);
        send_cmd(aes_pkg::op_encrypt, {128'h0, kat_pt});
        take_result($urandom_range(0, 7), r);

        // second command queued behind a held result
        send_cmd(aes_pkg::op_encrypt, {128'h0, kat_pt});
        fork
            send_cmd(aes_pkg::op_encrypt, {128'h0, kat_pt});
            take_result($urandom_range(4, 12), r);
        join
        take_result($urandom_range(0, 7), r);

        // random blocks, second pass must repeat the first
        for (int i = 0; i < 3; i++)
        begin
            pt = {$urandom, $urandom, $urandom, $urandom};
            set_expect(aes_pkg::st_ok, '0, 1'b0);
            send_cmd(aes_pkg::op_encrypt, {128'h0, pt});
            take_result($urandom_range(0, 7), r);
            set_expect(aes_pkg::st_ok, r.block, 1'b1);
            send_cmd(aes_pkg::op_encrypt, {128'h0, pt});
            take_result($urandom_range(0, 7), r);
        end

        // reset drops the stored key
        apply_reset();
        set_expect(aes_pkg::st_no_key, '0, 1'b1);
        send_cmd(aes_pkg::op_encrypt, {128'h0, kat_pt});
        take_result($urandom_range(0, 7), r);

        repeat (4) @(posedge clk);
        $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/aes_pkg.sv
hw/aes_cmd_port.sv
hw/aes_controller.sv
hw/aes_key_expand.sv
hw/aes_round_key_store.sv
hw/aes_cipher_core.sv
hw/aes_result_port.sv
hw/aes_device.sv
test/aes_device_tb.sv

// ==== Bender.yml ====
package:
  name: aes_device

sources:
  - include_dirs:
      - hw
    files:
      - hw/aes_pkg.sv
      - hw/aes_cmd_port.sv
      - hw/aes_controller.sv
      - hw/aes_key_expand.sv
      - hw/aes_round_key_store.sv
      - hw/aes_cipher_core.sv
      - hw/aes_result_port.sv
      - hw/aes_device.sv
      - target: test
        files:
          - test/aes_device_tb.sv
